// File: Makefile
# Verilator simulation of the texture front end

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f src.f --top-module textureLodUnitTb \
		-Mdir obj_dir -o textureLodUnitTb
	./obj_dir/textureLodUnitTb | tee sim.log
	grep -qx "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: dv/textureLodChecker.sv
// Texture front end checker
`timescale 1ns/1ps
`default_nettype none

module textureLodChecker
(
    input  logic                     aclk,
    input  logic                     rstN,
    input  logic                     ce,
    input  texConfPkg::texConf_t     conf,
    input  texFormatPkg::pixelIn_t   pixel,
    input  texFormatPkg::texelAddr_t result,
    output int                       checkCount,
    output int                       errorCount
);
    import texFormatPkg::*;
    import texConfPkg::*;

    // Expected results in pixel order
    int         expLod[$];
    int         expAddr[$];
    int         checks = 0;
    int         errors = 0;
    // Expected result.valid two enabled edges deep
    logic       stage1Valid;
    logic       stage2Valid;
    // Previous edge was enabled, so result may have moved
    logic       fresh;
    texelAddr_t lastResult;

    assign checkCount = checks;
    assign errorCount = errors;

    // Mip level from the diagonal neighbor difference
    function automatic int expectLevel(input texConf_t c, input pixelIn_t p);
        int dS;
        int dT;
        int mS;
        int mT;
        int foot;
        int lvl;
        int maxL;
        dS = p.s.raw - p.sXy.raw;
        dT = p.t.raw - p.tXy.raw;
        // Only the fraction part of the magnitude counts
        mS = (dS < 0 ? -dS : dS) & 32'h7fff;
        mT = (dT < 0 ? -dT : dT) & 32'h7fff;
        foot = ((mS >> 7) >> (8 - int'(c.widthLog2))) | ((mT >> 7) >> (8 - int'(c.heightLog2)));
        lvl = 0;
        while (foot != 0)
        begin
            lvl++;
            foot = foot >> 1;
        end
        if (!c.mipEnable)
            lvl = 0;
        maxL = (c.widthLog2 > c.heightLog2) ? int'(c.widthLog2) : int'(c.heightLog2);
        return (lvl > maxL) ? maxL : lvl;
    endfunction

    // Base level index of one axis
    function automatic int expectIndex(input texCoord_t coord, input wrapMode_t mode,
                                       input logic [3:0] sizeLog2);
        int raw;
        int size;
        raw = coord.raw;
        size = 1 << sizeLog2;
        // Floor of coord times size, modulo size
        if (mode == WRAP_REPEAT)
            return (raw >>> (15 - int'(sizeLog2))) & (size - 1);
        if (raw < 0)
            return 0;
        if (raw >= 32768)
            return size - 1;
        return (raw * size) / 32768;
    endfunction

    // Finer levels first, then row major inside the level
    function automatic int expectAddr(input texConf_t c, input int lvl, input int u, input int v);
        int base;
        int w;
        int h;
        base = 0;
        for (int k = 0; k < lvl; k++)
        begin
            w = (1 << c.widthLog2) >> k;
            h = (1 << c.heightLog2) >> k;
            base += ((w < 1) ? 1 : w) * ((h < 1) ? 1 : h);
        end
        w = (1 << c.widthLog2) >> lvl;
        return base + (v >> lvl) * ((w < 1) ? 1 : w) + (u >> lvl);
    endfunction

    always @(posedge aclk)
    begin : watch
        int   lvl;
        int   wantLod;
        int   wantAddr;
        logic ok;
        if (!rstN)
        begin
            stage1Valid = 1'b0;
            stage2Valid = 1'b0;
            fresh       = 1'b0;
            lastResult  = '0;
            expLod.delete();
            expAddr.delete();
        end
        else
        begin
            if (result.valid !== stage2Valid)
            begin
                $display("Mismatch at %0d ns: result.valid expected %0b got %0b",
                         $time, stage2Valid, result.valid);
                errors++;
            end
            // A stalled edge must leave the output alone
            if (!fresh && result !== lastResult)
            begin
                $display("Result changed at %0d ns although ce was low", $time);
                errors++;
            end
            if (fresh && result.valid)
            begin
                if (expLod.size() == 0)
                begin
                    $display("Result at %0d ns arrived with no pixel waiting for it", $time);
                    errors++;
                end
                else
                begin
                    wantLod  = expLod.pop_front();
                    wantAddr = expAddr.pop_front();
                    ok = 1'b1;
                    if (int'(result.lod) != wantLod)
                    begin
                        $display("Mismatch at %0d ns: result.lod expected %0d got %0d",
                                 $time, wantLod, result.lod);
                        ok = 1'b0;
                    end
                    if (int'(result.addr) != wantAddr)
                    begin
                        $display("Mismatch at %0d ns: result.addr expected %0d got %0d",
                                 $time, wantAddr, result.addr);
                        ok = 1'b0;
                    end
                    checks++;
                    if (!ok)
                        errors++;
                    $display("test %0d: lod %0d addr %0d %s", checks, result.lod, result.addr,
                             ok ? "ok" : "wrong");
                end
            end
            lastResult = result;
            fresh      = ce;
            if (ce)
            begin
                stage2Valid = stage1Valid;
                stage1Valid = pixel.valid;
                if (pixel.valid)
                begin
                    lvl = expectLevel(conf, pixel);
                    expLod.push_back(lvl);
                    expAddr.push_back(expectAddr(conf, lvl,
                        expectIndex(pixel.s, conf.wrapS, conf.widthLog2),
                        expectIndex(pixel.t, conf.wrapT, conf.heightLog2)));
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: dv/textureLodUnitTb.sv
// Texture front end testbench
`timescale 1ns/1ps
`default_nettype none

module textureLodUnitTb;
    import texFormatPkg::*;
    import texConfPkg::*;

    localparam int CLK_PERIOD = 10;

    // One pixel, its setup and the ce low cycles after it
    typedef struct {
        texConf_t conf;
        int       s;
        int       t;
        int       sXy;
        int       tXy;
        int       gap;
    } stimEntry_t;

    logic       aclk;
    logic       rstN;
    logic       ce;
    texConf_t   conf;
    pixelIn_t   pixel;
    texelAddr_t result;
    int         checkCount;
    int         errorCount;
    stimEntry_t stimTable[$];
    int         tableLen = 0;

    textureLodUnit dut0
    (
        .aclk   (aclk),
        .rstN   (rstN),
        .ce     (ce),
        .conf   (conf),
        .pixel  (pixel),
        .result (result)
    );

    textureLodChecker checker0
    (
        .aclk       (aclk),
        .rstN       (rstN),
        .ce         (ce),
        .conf       (conf),
        .pixel      (pixel),
        .result     (result),
        .checkCount (checkCount),
        .errorCount (errorCount)
    );

    initial
    begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    function automatic texConf_t makeConf(input logic mip, input int wLog, input int hLog,
                                          input wrapMode_t ws, input wrapMode_t wt);
        texConf_t c;
        c.mipEnable  = mip;
        c.widthLog2  = 4'(wLog);
        c.heightLog2 = 4'(hLog);
        c.wrapS      = ws;
        c.wrapT      = wt;
        c.reserved   = 1'b0;
        return c;
    endfunction

    task automatic addEntry(input texConf_t c, input int s, input int t, input int sXy,
                            input int tXy, input int gap);
        stimEntry_t e;
        e.conf = c;
        e.s    = s;
        e.t    = t;
        e.sXy  = sXy;
        e.tXy  = tXy;
        e.gap  = gap;
        stimTable.push_back(e);
    endtask

    // Coordinates in S16.15 where one texel of a 64 wide side is 512
    task automatic buildTable();
        texConf_t c64Off;
        texConf_t c64;
        texConf_t c64Clamp;
        texConf_t cRect;
        texConf_t cRand;
        int       s;
        int       t;
        c64Off   = makeConf(1'b0, 6, 6, WRAP_REPEAT, WRAP_REPEAT);
        c64      = makeConf(1'b1, 6, 6, WRAP_REPEAT, WRAP_REPEAT);
        c64Clamp = makeConf(1'b0, 6, 6, WRAP_CLAMP, WRAP_CLAMP);
        cRect    = makeConf(1'b1, 8, 4, WRAP_REPEAT, WRAP_REPEAT);
        cRand    = makeConf(1'b1, 7, 5, WRAP_REPEAT, WRAP_CLAMP);
        // Mipmapping off ignores the neighbor
        addEntry(c64Off, 5000, 9000, 13000, 1000, 0);
        addEntry(c64Off, 20000, 300, 20000, 300, 2);
        // One, two and four texels, zero, then most of the texture width
        addEntry(c64, 1000, 2000, 1512, 2000, 0);
        addEntry(c64, 1000, 2000, 1000, 3024, 0);
        addEntry(c64, 8000, 4000, 10048, 4000, 3);
        addEntry(c64, 8000, 4000, 8000, 4000, 0);
        addEntry(c64, 100, 200, 30100, 200, 1);
        // Negative and above 1.0 under repeat and then clamp
        addEntry(c64Off, -1636, 66236, -1636, 66236, 0);
        addEntry(c64Clamp, -1636, 66236, -1636, 66236, 0);
        addEntry(c64Clamp, 32768, 16000, 32768, 16000, 0);
        // 256x16 reaches levels where the height is already 1
        addEntry(cRect, 3000, 5000, 3512, 5000, 0);
        addEntry(cRect, 3000, 5000, 7096, 5000, 0);
        addEntry(cRect, 3000, 5000, 33000, 5000, 2);
        addEntry(cRect, 32000, 30000, 32000, 27000, 0);
        // Random coordinates from -1.0 to 2.0 with a nearby neighbor
        for (int i = 0; i < 8; i++)
        begin
            s = int'($urandom % 32'd98304) - 32768;
            t = int'($urandom % 32'd98304) - 32768;
            addEntry(cRand, s, t, s + int'($urandom % 32'd4096) - 2048,
                     t + int'($urandom % 32'd4096) - 2048, int'($urandom % 32'd3));
        end
    endtask

    task automatic applyEntry(input stimEntry_t e);
        // Drain pixels in flight before the setup changes
        if (e.conf != conf)
        begin
            repeat (2)
            begin
                @(posedge aclk);
                #1;
                ce          = 1'b1;
                pixel.valid = 1'b0;
            end
        end
        @(posedge aclk);
        #1;
        conf          = e.conf;
        ce            = 1'b1;
        pixel.valid   = 1'b1;
        pixel.s.raw   = e.s;
        pixel.t.raw   = e.t;
        pixel.sXy.raw = e.sXy;
        pixel.tXy.raw = e.tXy;
        repeat (e.gap)
        begin
            @(posedge aclk);
            #1;
            ce = 1'b0;
        end
    endtask

    initial
    begin : stimulus
        rstN  = 1'b0;
        ce    = 1'b0;
        conf  = '0;
        pixel = '0;
        void'($urandom(12));
        buildTable();
        tableLen = stimTable.size();
        repeat (3) @(posedge aclk);
        #1;
        rstN = 1'b1;
        // Enabled but empty so result.valid has to stay low
        repeat (3)
        begin
            @(posedge aclk);
            #1;
            ce = 1'b1;
        end
        foreach (stimTable[i])
            applyEntry(stimTable[i]);
        repeat (4)
        begin
            @(posedge aclk);
            #1;
            ce          = 1'b1;
            pixel.valid = 1'b0;
        end
        wait (checkCount == tableLen);
        @(posedge aclk);
        $display("%0d of %0d results checked, %0d errors", checkCount, tableLen, errorCount);
        if (errorCount == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

    // Generous bound of 20 cycles per table entry
    initial
    begin : watchdog
        wait (tableLen != 0);
        #(tableLen * 20 * CLK_PERIOD);
        $display("Timeout: only %0d of %0d results arrived", checkCount, tableLen);
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
verilog/texConfPkg.sv
verilog/texFormatPkg.sv
verilog/lodCalculator.sv
verilog/texelWrap.sv
verilog/mipAddressGen.sv
verilog/textureLodUnit.sv
dv/textureLodChecker.sv
dv/textureLodUnitTb.sv

// File: verilog/lodCalculator.sv
// Mip level of detail calculator
`timescale 1ns/1ps
`default_nettype none

module lodCalculator
(
    input  logic                            aclk,
    input  logic                            rstN,
    input  logic                            ce,
    input  texConfPkg::texConf_t            conf,
    input  texFormatPkg::pixelIn_t          pixel,
    output logic [texConfPkg::LOD_BITS-1:0] lod,
    output logic                            lodValid
);
    import texFormatPkg::*;
    import texConfPkg::*;

    logic signed [31:0]   diffS;
    logic signed [31:0]   diffT;
    logic [FRAC_BITS-1:0] magS;
    logic [FRAC_BITS-1:0] magT;
    logic [IDX_BITS-1:0]  footS;
    logic [IDX_BITS-1:0]  footT;
    logic [IDX_BITS-1:0]  footprint;
    logic [LOD_BITS-1:0]  lodNext;

    // Screen space derivative along the diagonal
    assign diffS = pixel.s.raw - pixel.sXy.raw;
    assign diffT = pixel.t.raw - pixel.tXy.raw;

    // Magnitude of the fraction part only
    assign magS = diffS[31] ? (~diffS[FRAC_BITS-1:0]) + 15'd1 : diffS[FRAC_BITS-1:0];
    assign magT = diffT[31] ? (~diffT[FRAC_BITS-1:0]) + 15'd1 : diffT[FRAC_BITS-1:0];

    // Top fraction bits scaled to texels of each axis
    assign footS = magS[FRAC_BITS-1 -: IDX_BITS] >> (4'(MAX_SIZE_LOG2) - conf.widthLog2);
    assign footT = magT[FRAC_BITS-1 -: IDX_BITS] >> (4'(MAX_SIZE_LOG2) - conf.heightLog2);

    // Either axis may set the footprint
    assign footprint = footS | footT;

    // Highest set bit plus one, zero footprint stays on level 0
    always_comb
    begin
        lodNext = '0;
        for (int i = 0; i < IDX_BITS; i++)
        begin
            if (footprint[i])
            begin
                lodNext = LOD_BITS'(i + 1);
            end
        end
    end

    always_ff @(posedge aclk)
    begin
        if (!rstN)
        begin
            lod      <= '0;
            lodValid <= 1'b0;
        end
        else if (ce)
        begin
            // Mipmapping off pins the base level
            lod      <= conf.mipEnable ? lodNext : '0;
            lodValid <= pixel.valid;
        end
    end

    // Size logs beyond 256 would underflow the shift above
    sizeLogInRange: assert property (@(posedge aclk) disable iff (!rstN)
        (ce && pixel.valid) |->
            (conf.widthLog2 <= MAX_SIZE_LOG2) && (conf.heightLog2 <= MAX_SIZE_LOG2))
        else $error("lodCalculator: texture size log out of range");

endmodule

`default_nettype wire

// File: verilog/mipAddressGen.sv
// Mip chain address generator
`timescale 1ns/1ps
`default_nettype none

module mipAddressGen
(
    input  logic                            aclk,
    input  logic                            rstN,
    input  logic                            ce,
    input  texConfPkg::texConf_t            conf,
    input  logic [texConfPkg::LOD_BITS-1:0] lod,
    input  logic                            lodValid,
    input  texFormatPkg::texelIdx_t         idx,
    output texFormatPkg::texelAddr_t        result
);
    import texFormatPkg::*;
    import texConfPkg::*;

    logic [3:0]           maxLog;
    logic [LOD_BITS-1:0]  lodClamped;
    logic [ADDR_BITS-1:0] levelBase;
    logic [3:0]           levelWidthLog;
    logic [IDX_BITS-1:0]  uScaled;
    logic [IDX_BITS-1:0]  vScaled;
    logic [ADDR_BITS-1:0] addrNext;

    // Side log at a given level, a side never drops below one texel
    function automatic logic [3:0] levelLog
    (
        input logic [3:0] sizeLog2,
        input logic [3:0] level
    );
        return (sizeLog2 > level) ? sizeLog2 - level : 4'd0;
    endfunction

    // Last level is the 1x1 one, reached by the longer side
    assign maxLog     = (conf.widthLog2 > conf.heightLog2) ? conf.widthLog2 : conf.heightLog2;
    assign lodClamped = (lod > maxLog) ? maxLog : lod;

    // Chain offset is the area of every finer level
    always_comb
    begin : baseSum
        logic [4:0] areaLog;
        levelBase = '0;
        areaLog   = '0;
        for (int k = 0; k < MAX_SIZE_LOG2; k++)
        begin
            if (k < lodClamped)
            begin
                areaLog   = {1'b0, levelLog(conf.widthLog2, 4'(k))} +
                            {1'b0, levelLog(conf.heightLog2, 4'(k))};
                levelBase = levelBase + (ADDR_BITS'(1) << areaLog);
            end
        end
    end

    // Base level indices down to the selected level
    assign levelWidthLog = levelLog(conf.widthLog2, lodClamped);
    assign uScaled       = idx.u >> lodClamped;
    assign vScaled       = idx.v >> lodClamped;

    // Row major inside the level
    assign addrNext = levelBase + (ADDR_BITS'(vScaled) << levelWidthLog) + ADDR_BITS'(uScaled);

    always_ff @(posedge aclk)
    begin
        if (!rstN)
        begin
            result <= '0;
        end
        else if (ce)
        begin
            result.valid <= lodValid && idx.valid;
            result.lod   <= lodClamped;
            result.addr  <= addrNext;
        end
    end

    // Both parallel stages see the same pixel on the same edge
    stagesAligned: assert property (@(posedge aclk) disable iff (!rstN)
        lodValid == idx.valid)
        else $error("mipAddressGen: level and index stages out of step");

endmodule

`default_nettype wire

// File: verilog/texConfPkg.sv
// Texture configuration
`default_nettype none

package texConfPkg;

    // Largest side is 256 texels
    localparam int MAX_SIZE_LOG2 = 8;

    // Levels 0 to 8 need four bits
    localparam int LOD_BITS = 4;

    // Full chain of a 256x256 texture is 87381 texels
    localparam int ADDR_BITS = 17;

    // Per axis behavior outside 0.0 to 1.0
    typedef enum logic {
        WRAP_REPEAT = 1'b0,
        WRAP_CLAMP  = 1'b1
    } wrapMode_t;

    // Static texture setup, held while pixels flow
    typedef struct packed {
        // Mip selection on, else level 0 always
        logic      mipEnable;
        // Side lengths as log2, 0 to 8
        logic [3:0] widthLog2;
        logic [3:0] heightLog2;
        wrapMode_t wrapS;
        wrapMode_t wrapT;
        logic      reserved;
    } texConf_t;

endpackage

`default_nettype wire

// File: verilog/texFormatPkg.sv
// Texel coordinate formats
`default_nettype none

package texFormatPkg;

    // S16.15 layout
    localparam int FRAC_BITS = 15;
    localparam int INT_BITS = 16;

    // Base level index width, one bit per size doubling
    localparam int IDX_BITS = texConfPkg::MAX_SIZE_LOG2;

    // Field view of an S16.15 word, used by wrapping
    typedef struct packed {
        logic                sign;
        logic [INT_BITS-1:0] intPart;
        logic [FRAC_BITS-1:0] frac;
    } coordFields_t;

    // Raw view for subtraction, field view for wrapping
    typedef union packed {
        logic signed [31:0] raw;
        coordFields_t       fields;
    } texCoord_t;

    // One pixel and its diagonal screen space neighbor
    typedef struct packed {
        logic      valid;
        texCoord_t s;
        texCoord_t t;
        // Neighbor at x+1, y+1, only used for the level
        texCoord_t sXy;
        texCoord_t tXy;
    } pixelIn_t;

    // Wrapped base level texel indices
    typedef struct packed {
        logic                valid;
        logic [IDX_BITS-1:0] u;
        logic [IDX_BITS-1:0] v;
    } texelIdx_t;

    // Linear address inside the packed mip chain
    typedef struct packed {
        logic                                 valid;
        logic [texConfPkg::LOD_BITS-1:0]      lod;
        logic [texConfPkg::ADDR_BITS-1:0]     addr;
    } texelAddr_t;

endpackage

`default_nettype wire

// File: verilog/texelWrap.sv
// Texel coordinate wrapper
`timescale 1ns/1ps
`default_nettype none

module texelWrap
(
    input  logic                    aclk,
    input  logic                    rstN,
    input  logic                    ce,
    input  texConfPkg::texConf_t    conf,
    input  texFormatPkg::pixelIn_t  pixel,
    output texFormatPkg::texelIdx_t idx
);
    import texFormatPkg::*;
    import texConfPkg::*;

    logic [IDX_BITS-1:0] uNext;
    logic [IDX_BITS-1:0] vNext;

    // One axis, repeat or clamp to edge
    function automatic logic [IDX_BITS-1:0] wrapAxis
    (
        input texCoord_t  coord,
        input wrapMode_t  mode,
        input logic [3:0] sizeLog2
    );
        logic [IDX_BITS-1:0] scaled;
        logic [IDX_BITS:0]   lastIdx;
        // Fraction as texels, two's complement gives repeat for free
        scaled = IDX_BITS'(coord.fields.frac >> (4'(FRAC_BITS) - sizeLog2));
        lastIdx = (9'd1 << sizeLog2) - 9'd1;
        if (mode == WRAP_REPEAT)
        begin
            return scaled;
        end
        // Below 0.0
        if (coord.fields.sign)
        begin
            return '0;
        end
        // At or above 1.0
        if (coord.fields.intPart != '0)
        begin
            return lastIdx[IDX_BITS-1:0];
        end
        return scaled;
    endfunction

    assign uNext = wrapAxis(pixel.s, conf.wrapS, conf.widthLog2);
    assign vNext = wrapAxis(pixel.t, conf.wrapT, conf.heightLog2);

    always_ff @(posedge aclk)
    begin
        if (!rstN)
        begin
            idx.valid <= 1'b0;
        end
        else if (ce)
        begin
            idx.valid <= pixel.valid;
            idx.u     <= uNext;
            idx.v     <= vNext;
        end
    end

    // Indices never leave the base level
    idxInTexture: assert property (@(posedge aclk) disable iff (!rstN)
        idx.valid |->
            ({1'b0, idx.u} < (9'd1 << conf.widthLog2)) &&
            ({1'b0, idx.v} < (9'd1 << conf.heightLog2)))
        else $error("texelWrap: index outside texture");

endmodule

`default_nettype wire

// File: verilog/textureLodUnit.sv
// Texture sampling front end
`timescale 1ns/1ps
`default_nettype none

module textureLodUnit
(
    input  logic                     aclk,
    input  logic                     rstN,
    // Low stalls the whole pipeline
    input  logic                     ce,
    input  texConfPkg::texConf_t     conf,
    input  texFormatPkg::pixelIn_t   pixel,
    output texFormatPkg::texelAddr_t result
);
    import texFormatPkg::*;
    import texConfPkg::*;

    // Stage one outputs, aligned on the same enabled edge
    logic [LOD_BITS-1:0] lod;
    logic                lodValid;
    texelIdx_t           idx;

    // Level from the neighbor difference
    lodCalculator lodCalc0
    (
        .aclk     (aclk),
        .rstN     (rstN),
        .ce       (ce),
        .conf     (conf),
        .pixel    (pixel),
        .lod      (lod),
        .lodValid (lodValid)
    );

    // Base level indices of the rendered pixel
    texelWrap texelWrap0
    (
        .aclk  (aclk),
        .rstN  (rstN),
        .ce    (ce),
        .conf  (conf),
        .pixel (pixel),
        .idx   (idx)
    );

    // Second stage joins both into one address
    mipAddressGen mipAddrGen0
    (
        .aclk     (aclk),
        .rstN     (rstN),
        .ce       (ce),
        .conf     (conf),
        .lod      (lod),
        .lodValid (lodValid),
        .idx      (idx),
        .result   (result)
    );

endmodule

`default_nettype wire
